/* filelist.f */
ara_pkg.sv
lane.sv
vlsu.sv
ara_dispatcher.sv
ara_sequencer.sv
ara.sv
ara_checker.sv
tb_ara.sv

/* tb_ara.sv */
//////////////////////////////
// Ara testbench
// Random instruction stream, memory responder and watchdog
//////////////////////////////

`timescale 1ns/1ps

module tb_ara;

  import ara_pkg::*;

  // Loads and moves, ALU and store pairs, scalar add triples
  localparam int NumAluPairs = 12;
  localparam int NumAddx     = 4;
  localparam int NumInstr    = 2 * NrVRegs + 2 * NumAluPairs + 3 * NumAddx;

  logic      clk_i;
  logic      reset_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  op_e       acc_op_i;
  vreg_t     acc_vd_i;
  vreg_t     acc_vs1_i;
  vreg_t     acc_vs2_i;
  elem_t     acc_scalar_i;
  mem_addr_t acc_addr_i;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;
  elem_t     acc_resp_result_o;
  logic      mem_req_o;
  logic      mem_we_o;
  mem_addr_t mem_addr_o;
  elem_t     mem_wdata_o;
  elem_t     mem_rdata_i;

  integer    seed;
  int        issued;
  int        tb_err_cnt;
  int        chk_err_cnt;
  int        chk_resp_cnt;
  logic      rd_pend;
  mem_addr_t rd_addr;
  vreg_t     vd;

  ara dut (.*);

  ara_checker chk (
    .clk_i            (clk_i            ),
    .reset_i          (reset_i          ),
    .acc_req_valid_i  (acc_req_valid_i  ),
    .acc_req_ready_i  (acc_req_ready_o  ),
    .acc_op_i         (acc_op_i         ),
    .acc_vd_i         (acc_vd_i         ),
    .acc_vs1_i        (acc_vs1_i        ),
    .acc_vs2_i        (acc_vs2_i        ),
    .acc_scalar_i     (acc_scalar_i     ),
    .acc_addr_i       (acc_addr_i       ),
    .acc_resp_valid_i (acc_resp_valid_o ),
    .acc_resp_ready_i (acc_resp_ready_i ),
    .acc_resp_result_i(acc_resp_result_o),
    .mem_req_i        (mem_req_o        ),
    .mem_we_i         (mem_we_o         ),
    .mem_addr_i       (mem_addr_o       ),
    .mem_wdata_i      (mem_wdata_o      ),
    .err_cnt_o        (chk_err_cnt      ),
    .resp_cnt_o       (chk_resp_cnt     )
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  //////////////////////////////
  // Memory responder
  //////////////////////////////

  function automatic elem_t mem_word(mem_addr_t a);
    return (elem_t'(a) * 32'h9E37) ^ 32'hA5A50000;
  endfunction

  always @(posedge clk_i) begin
    rd_pend <= mem_req_o && !mem_we_o;
    rd_addr <= mem_addr_o;
  end

  // Read data shows up in the cycle after the read
  always @(negedge clk_i) begin
    mem_rdata_i <= rd_pend ? mem_word(rd_addr) : '0;
  end

  //////////////////////////////
  // Instruction driver
  //////////////////////////////

  task automatic send_instr(op_e op, vreg_t vd_a, vreg_t vs1, vreg_t vs2, elem_t scalar,
                            mem_addr_t addr);
    int wait_cnt;
    int hold;
    wait_cnt = 0;
    @(negedge clk_i);
    while (!acc_req_ready_o && wait_cnt < 40) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (!acc_req_ready_o) begin
      $display("Error: DUT never became ready for instruction %0d", issued);
      tb_err_cnt++;
      return;
    end
    acc_req_valid_i = 1'b1;
    acc_op_i        = op;
    acc_vd_i        = vd_a;
    acc_vs1_i       = vs1;
    acc_vs2_i       = vs2;
    acc_scalar_i    = scalar;
    acc_addr_i      = addr;
    @(negedge clk_i);
    acc_req_valid_i = 1'b0;
    issued++;
    wait_cnt = 0;
    while (!acc_resp_valid_o && wait_cnt < 40) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (!acc_resp_valid_o) begin
      $display("Error: no response for instruction %0d (%s)", issued - 1, op.name());
      tb_err_cnt++;
      return;
    end
    // Random back-pressure before the core takes the response
    hold = $unsigned($random(seed)) % 6;
    repeat (hold) @(negedge clk_i);
    acc_resp_ready_i = 1'b1;
    @(negedge clk_i);
    acc_resp_ready_i = 1'b0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed             = 32'h4455;
    issued           = 0;
    tb_err_cnt       = 0;
    reset_i          = 1'b1;
    acc_req_valid_i  = 1'b0;
    acc_op_i         = VADD;
    acc_vd_i         = '0;
    acc_vs1_i        = '0;
    acc_vs2_i        = '0;
    acc_scalar_i     = '0;
    acc_addr_i       = '0;
    acc_resp_ready_i = 1'b0;
    mem_rdata_i      = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);

    // Fill every register, then read back element 0
    for (int r = 0; r < NrVRegs; r++) begin
      send_instr(VLE, vreg_t'(r), '0, '0, '0, mem_addr_t'($random(seed)));
    end
    for (int r = 0; r < NrVRegs; r++) begin
      send_instr(VMVXS, '0, '0, vreg_t'(r), '0, '0);
    end

    for (int n = 0; n < NumAluPairs; n++) begin
      vd = vreg_t'($random(seed));
      send_instr(op_e'($unsigned($random(seed)) % 5), vd, vreg_t'($random(seed)),
                 vreg_t'($random(seed)), elem_t'($random(seed)), '0);
      send_instr(VSE, '0, '0, vd, '0, mem_addr_t'($random(seed)));
    end

    for (int n = 0; n < NumAddx; n++) begin
      vd = vreg_t'($random(seed));
      send_instr(VADDX, vd, '0, vreg_t'($random(seed)), elem_t'($random(seed)), '0);
      send_instr(VSE, '0, '0, vd, '0, mem_addr_t'($random(seed)));
      send_instr(VMVXS, '0, '0, vd, '0, '0);
    end

    repeat (4) @(negedge clk_i);
    if (chk_resp_cnt != issued || issued != NumInstr) begin
      $display("Error: %0d instructions issued, %0d responses seen", issued, chk_resp_cnt);
      tb_err_cnt++;
    end
    $display("Errors: %0d checker, %0d testbench", chk_err_cnt, tb_err_cnt);
    if (chk_err_cnt == 0 && tb_err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the instruction count
  initial begin
    #(NumInstr * 40 * 8);
    $display("Error: watchdog expired before the instruction stream finished");
    $display("Test failed");
    $finish;
  end

endmodule : tb_ara

/* ara_checker.sv */
//////////////////////////////
// Ara checker
// Mirrors the vector register file from accepted requests and
// compares responses and memory writes against it
//////////////////////////////

`timescale 1ns/1ps

module ara_checker (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               acc_req_valid_i,
  input  logic               acc_req_ready_i,
  input  ara_pkg::op_e       acc_op_i,
  input  ara_pkg::vreg_t     acc_vd_i,
  input  ara_pkg::vreg_t     acc_vs1_i,
  input  ara_pkg::vreg_t     acc_vs2_i,
  input  ara_pkg::elem_t     acc_scalar_i,
  input  ara_pkg::mem_addr_t acc_addr_i,
  input  logic               acc_resp_valid_i,
  input  logic               acc_resp_ready_i,
  input  ara_pkg::elem_t     acc_resp_result_i,
  input  logic               mem_req_i,
  input  logic               mem_we_i,
  input  ara_pkg::mem_addr_t mem_addr_i,
  input  ara_pkg::elem_t     mem_wdata_i,
  output int                 err_cnt_o,
  output int                 resp_cnt_o
);

  import ara_pkg::*;

  // Model register file by vector element
  elem_t     model [NrVRegs][VLenElems];
  logic      in_reset;
  logic      pend;
  op_e       exp_op;
  elem_t     exp_result;
  vreg_t     st_vreg;
  mem_addr_t st_addr;
  int        wr_cnt;
  logic      hold_q;
  elem_t     held_result;
  int        i;

  // Memory read rule of the responder
  function automatic elem_t mem_word(mem_addr_t a);
    return (elem_t'(a) * 32'h9E37) ^ 32'hA5A50000;
  endfunction

  task automatic flag_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    err_cnt_o++;
  endtask

  initial begin
    err_cnt_o  = 0;
    resp_cnt_o = 0;
    in_reset   = 1'b0;
    pend       = 1'b0;
    hold_q     = 1'b0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < VLenElems; e++) begin
        model[r][e] = '0;
      end
    end
  end

  //////////////////////////////
  // Model update on acceptance
  //////////////////////////////

  task automatic accept_request();
    exp_op     = acc_op_i;
    exp_result = '0;
    pend       = 1'b1;
    for (i = 0; i < VLenElems; i++) begin
      case (acc_op_i)
        VADD:  model[acc_vd_i][i] = model[acc_vs2_i][i] + model[acc_vs1_i][i];
        VSUB:  model[acc_vd_i][i] = model[acc_vs2_i][i] - model[acc_vs1_i][i];
        VAND:  model[acc_vd_i][i] = model[acc_vs2_i][i] & model[acc_vs1_i][i];
        VOR:   model[acc_vd_i][i] = model[acc_vs2_i][i] | model[acc_vs1_i][i];
        VXOR:  model[acc_vd_i][i] = model[acc_vs2_i][i] ^ model[acc_vs1_i][i];
        VADDX: model[acc_vd_i][i] = model[acc_vs2_i][i] + acc_scalar_i;
        VLE:   model[acc_vd_i][i] = mem_word(acc_addr_i + mem_addr_t'(i));
        default: ;
      endcase
    end
    if (acc_op_i == VMVXS) begin
      exp_result = model[acc_vs2_i][0];
    end
    st_vreg = acc_vs2_i;
    st_addr = acc_addr_i;
    wr_cnt  = 0;
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      in_reset = 1'b1;
      pend     = 1'b0;
      hold_q   = 1'b0;
    end else begin
      if (in_reset) begin
        if (acc_resp_valid_i !== 1'b0 || mem_req_i !== 1'b0 || acc_req_ready_i !== 1'b1) begin
          flag_error("outputs not idle after reset");
        end
        in_reset = 1'b0;
      end

      // Back-pressure keeps the response stable
      if (hold_q) begin
        if (acc_resp_valid_i !== 1'b1 || acc_resp_result_i !== held_result) begin
          flag_error("response changed while held");
        end
      end

      // Only one instruction in flight at the top level
      if (pend && acc_req_ready_i !== 1'b0) begin
        flag_error("request ready while an instruction is in flight");
      end

      if (mem_req_i && mem_we_i) begin
        if (!pend || exp_op != VSE || wr_cnt >= VLenElems) begin
          flag_error("unexpected memory write");
        end else begin
          if (mem_addr_i !== st_addr + mem_addr_t'(wr_cnt)) begin
            flag_error($sformatf("store address %h, expected %h", mem_addr_i,
                                 st_addr + mem_addr_t'(wr_cnt)));
          end
          if (mem_wdata_i !== model[st_vreg][wr_cnt]) begin
            flag_error($sformatf("store data %h, expected %h", mem_wdata_i,
                                 model[st_vreg][wr_cnt]));
          end
          wr_cnt++;
        end
      end

      if (acc_resp_valid_i && !pend) begin
        flag_error("response valid without an instruction in flight");
      end else if (acc_resp_valid_i && acc_resp_ready_i) begin
        if (acc_resp_result_i !== exp_result) begin
          flag_error($sformatf("%s result %h, expected %h", exp_op.name(),
                               acc_resp_result_i, exp_result));
        end
        if (exp_op == VSE && wr_cnt != VLenElems) begin
          flag_error($sformatf("store made %0d writes, expected %0d", wr_cnt, VLenElems));
        end
        pend = 1'b0;
        resp_cnt_o++;
      end

      if (acc_req_valid_i && acc_req_ready_i) begin
        accept_request();
      end

      hold_q      = acc_resp_valid_i && !acc_resp_ready_i;
      held_result = acc_resp_result_i;
    end
  end

endmodule : ara_checker

/* ara.sv */
//////////////////////////////
// Ara vector coprocessor top
// Dispatcher, sequencer, lanes and load/store unit
//////////////////////////////

`timescale 1ns/1ps

module ara (
  input  logic               clk_i,
  input  logic               reset_i,
  // Core request
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  input  ara_pkg::op_e       acc_op_i,
  input  ara_pkg::vreg_t     acc_vd_i,
  input  ara_pkg::vreg_t     acc_vs1_i,
  input  ara_pkg::vreg_t     acc_vs2_i,
  input  ara_pkg::elem_t     acc_scalar_i,
  input  ara_pkg::mem_addr_t acc_addr_i,
  // Core response
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  output ara_pkg::elem_t     acc_resp_result_o,
  // Memory port
  output logic               mem_req_o,
  output logic               mem_we_o,
  output ara_pkg::mem_addr_t mem_addr_o,
  output ara_pkg::elem_t     mem_wdata_o,
  input  ara_pkg::elem_t     mem_rdata_i
);

  import ara_pkg::*;

  //////////////////////////////
  // Dispatcher
  //////////////////////////////

  logic      ara_req_valid;
  logic      ara_req_ready;
  op_e       ara_op;
  vreg_t     ara_vd;
  vreg_t     ara_vs1;
  vreg_t     ara_vs2;
  elem_t     ara_scalar;
  mem_addr_t ara_addr;
  pe_e       ara_target;
  logic      ara_done;
  elem_t     ara_result;

  ara_dispatcher i_dispatcher (
    .clk_i            (clk_i            ),
    .reset_i          (reset_i          ),
    .acc_req_valid_i  (acc_req_valid_i  ),
    .acc_req_ready_o  (acc_req_ready_o  ),
    .acc_op_i         (acc_op_i         ),
    .acc_vd_i         (acc_vd_i         ),
    .acc_vs1_i        (acc_vs1_i        ),
    .acc_vs2_i        (acc_vs2_i        ),
    .acc_scalar_i     (acc_scalar_i     ),
    .acc_addr_i       (acc_addr_i       ),
    .acc_resp_valid_o (acc_resp_valid_o ),
    .acc_resp_ready_i (acc_resp_ready_i ),
    .acc_resp_result_o(acc_resp_result_o),
    .ara_req_valid_o  (ara_req_valid    ),
    .ara_req_ready_i  (ara_req_ready    ),
    .ara_op_o         (ara_op           ),
    .ara_vd_o         (ara_vd           ),
    .ara_vs1_o        (ara_vs1          ),
    .ara_vs2_o        (ara_vs2          ),
    .ara_scalar_o     (ara_scalar       ),
    .ara_addr_o       (ara_addr         ),
    .ara_target_o     (ara_target       ),
    .ara_done_i       (ara_done         ),
    .ara_result_i     (ara_result       )
  );

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  op_e                pe_op;
  vreg_t              pe_vd;
  vreg_t              pe_vs1;
  vreg_t              pe_vs2;
  elem_t              pe_scalar;
  mem_addr_t          pe_addr;
  logic               lanes_req;
  logic               vlsu_req;
  logic [NrLanes-1:0] lane_done;
  logic               vlsu_done;
  elem_t              lane_elem0 [NrLanes];

  ara_sequencer i_sequencer (
    .clk_i          (clk_i        ),
    .reset_i        (reset_i      ),
    .ara_req_valid_i(ara_req_valid),
    .ara_req_ready_o(ara_req_ready),
    .ara_op_i       (ara_op       ),
    .ara_vd_i       (ara_vd       ),
    .ara_vs1_i      (ara_vs1      ),
    .ara_vs2_i      (ara_vs2      ),
    .ara_scalar_i   (ara_scalar   ),
    .ara_addr_i     (ara_addr     ),
    .ara_target_i   (ara_target   ),
    .ara_done_o     (ara_done     ),
    .ara_result_o   (ara_result   ),
    // Each unit takes its own steered strobe
    .pe_req_valid_o (             ),
    .pe_op_o        (pe_op        ),
    .pe_vd_o        (pe_vd        ),
    .pe_vs1_o       (pe_vs1       ),
    .pe_vs2_o       (pe_vs2       ),
    .pe_scalar_o    (pe_scalar    ),
    .pe_addr_o      (pe_addr      ),
    .lanes_req_o    (lanes_req    ),
    .vlsu_req_o     (vlsu_req     ),
    .lane_done_i    (lane_done    ),
    .vlsu_done_i    (vlsu_done    ),
    .scalar_elem_i  (lane_elem0[0])
  );

  //////////////////////////////
  // Lanes
  //////////////////////////////

  logic [NrLanes-1:0] ldu_we;
  vreg_t              ldu_vreg;
  lane_idx_t          ldu_idx;
  elem_t              ldu_wdata;
  vreg_t              stu_vreg;
  lane_idx_t          stu_idx;
  elem_t              stu_rdata [NrLanes];

  for (genvar g = 0; g < NrLanes; g++) begin : gen_lanes
    lane i_lane (
      .clk_i      (clk_i        ),
      .reset_i    (reset_i      ),
      .lane_req_i (lanes_req    ),
      .op_i       (pe_op        ),
      .vd_i       (pe_vd        ),
      .vs1_i      (pe_vs1       ),
      .vs2_i      (pe_vs2       ),
      .scalar_i   (pe_scalar    ),
      .lane_done_o(lane_done[g] ),
      .ldu_we_i   (ldu_we[g]    ),
      .ldu_vreg_i (ldu_vreg     ),
      .ldu_idx_i  (ldu_idx      ),
      .ldu_wdata_i(ldu_wdata    ),
      .stu_vreg_i (stu_vreg     ),
      .stu_idx_i  (stu_idx      ),
      .stu_rdata_o(stu_rdata[g] ),
      .elem0_o    (lane_elem0[g])
    );
  end : gen_lanes

  //////////////////////////////
  // Load/store unit
  //////////////////////////////

  vlsu i_vlsu (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .vlsu_req_i (vlsu_req   ),
    .op_i       (pe_op      ),
    .vd_i       (pe_vd      ),
    .vs2_i      (pe_vs2     ),
    .addr_i     (pe_addr    ),
    .vlsu_done_o(vlsu_done  ),
    .mem_req_o  (mem_req_o  ),
    .mem_we_o   (mem_we_o   ),
    .mem_addr_o (mem_addr_o ),
    .mem_wdata_o(mem_wdata_o),
    .mem_rdata_i(mem_rdata_i),
    .ldu_we_o   (ldu_we     ),
    .ldu_vreg_o (ldu_vreg   ),
    .ldu_idx_o  (ldu_idx    ),
    .ldu_wdata_o(ldu_wdata  ),
    .stu_vreg_o (stu_vreg   ),
    .stu_idx_o  (stu_idx    ),
    .stu_rdata_i(stu_rdata  )
  );

endmodule : ara

/* ara_sequencer.sv */
//////////////////////////////
// Ara sequencer
// Issues one instruction at a time and waits for its unit to finish
//////////////////////////////

`timescale 1ns/1ps

module ara_sequencer (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // Dispatcher
  input  logic                          ara_req_valid_i,
  output logic                          ara_req_ready_o,
  input  ara_pkg::op_e                  ara_op_i,
  input  ara_pkg::vreg_t                ara_vd_i,
  input  ara_pkg::vreg_t                ara_vs1_i,
  input  ara_pkg::vreg_t                ara_vs2_i,
  input  ara_pkg::elem_t                ara_scalar_i,
  input  ara_pkg::mem_addr_t            ara_addr_i,
  input  ara_pkg::pe_e                  ara_target_i,
  output logic                          ara_done_o,
  output ara_pkg::elem_t                ara_result_o,
  // Processing elements
  output logic                          pe_req_valid_o,
  output ara_pkg::op_e                  pe_op_o,
  output ara_pkg::vreg_t                pe_vd_o,
  output ara_pkg::vreg_t                pe_vs1_o,
  output ara_pkg::vreg_t                pe_vs2_o,
  output ara_pkg::elem_t                pe_scalar_o,
  output ara_pkg::mem_addr_t            pe_addr_o,
  output logic                          lanes_req_o,
  output logic                          vlsu_req_o,
  input  logic [ara_pkg::NrLanes-1:0]   lane_done_i,
  input  logic                          vlsu_done_i,
  // Lane 0 element 0 of vs2
  input  ara_pkg::elem_t                scalar_elem_i
);

  import ara_pkg::*;

  seq_state_e         state_q;
  seq_state_e         state_d;
  pe_e                target_q;
  // Sticky done flags, one per lane
  logic [NrLanes-1:0] lane_seen_q;
  logic               unit_done;

  assign ara_req_ready_o = (state_q == Idle);
  assign pe_req_valid_o  = (state_q == Issue);
  assign lanes_req_o     = pe_req_valid_o && (target_q == PeLanes);
  assign vlsu_req_o      = pe_req_valid_o && (target_q == PeVlsu);
  assign ara_done_o      = (state_q == Done);

  assign unit_done = (target_q == PeLanes) ? &(lane_seen_q | lane_done_i) : vlsu_done_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:    if (ara_req_valid_i) state_d = Issue;
      Issue:   state_d = Wait;
      Wait:    if (unit_done) state_d = Done;
      Done:    state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= Idle;
      lane_seen_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == Issue) begin
        lane_seen_q <= '0;
      end else if (state_q == Wait) begin
        lane_seen_q <= lane_seen_q | lane_done_i;
      end
    end
  end

  // Broadcast fields stay stable until the next request
  always_ff @(posedge clk_i) begin
    if (ara_req_valid_i && ara_req_ready_o) begin
      pe_op_o     <= ara_op_i;
      pe_vd_o     <= ara_vd_i;
      pe_vs1_o    <= ara_vs1_i;
      pe_vs2_o    <= ara_vs2_i;
      pe_scalar_o <= ara_scalar_i;
      pe_addr_o   <= ara_addr_i;
      target_q    <= ara_target_i;
    end
    if (state_q == Wait && unit_done) begin
      ara_result_o <= scalar_elem_i;
    end
  end

endmodule : ara_sequencer

/* ara_dispatcher.sv */
//////////////////////////////
// Ara dispatcher
// Takes one core request at a time, picks the target unit and
// holds the response until the core accepts it
//////////////////////////////

`timescale 1ns/1ps

module ara_dispatcher (
  input  logic               clk_i,
  input  logic               reset_i,
  // Core request
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  input  ara_pkg::op_e       acc_op_i,
  input  ara_pkg::vreg_t     acc_vd_i,
  input  ara_pkg::vreg_t     acc_vs1_i,
  input  ara_pkg::vreg_t     acc_vs2_i,
  input  ara_pkg::elem_t     acc_scalar_i,
  input  ara_pkg::mem_addr_t acc_addr_i,
  // Core response
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  output ara_pkg::elem_t     acc_resp_result_o,
  // Sequencer
  output logic               ara_req_valid_o,
  input  logic               ara_req_ready_i,
  output ara_pkg::op_e       ara_op_o,
  output ara_pkg::vreg_t     ara_vd_o,
  output ara_pkg::vreg_t     ara_vs1_o,
  output ara_pkg::vreg_t     ara_vs2_o,
  output ara_pkg::elem_t     ara_scalar_o,
  output ara_pkg::mem_addr_t ara_addr_o,
  output ara_pkg::pe_e       ara_target_o,
  input  logic               ara_done_i,
  input  ara_pkg::elem_t     ara_result_i
);

  import ara_pkg::*;

  // Set from acceptance until the response is taken
  logic busy_q;
  logic accept;
  logic resp_taken;

  assign acc_req_ready_o = !busy_q;
  assign accept          = acc_req_valid_i && acc_req_ready_o;
  assign resp_taken      = acc_resp_valid_o && acc_resp_ready_i;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q           <= 1'b0;
      ara_req_valid_o  <= 1'b0;
      acc_resp_valid_o <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (resp_taken) begin
        busy_q <= 1'b0;
      end

      if (ara_req_valid_o && ara_req_ready_i) begin
        ara_req_valid_o <= 1'b0;
      end else if (accept) begin
        ara_req_valid_o <= 1'b1;
      end

      // Response stays up until the core takes it
      if (ara_done_i) begin
        acc_resp_valid_o <= 1'b1;
      end else if (resp_taken) begin
        acc_resp_valid_o <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Request and response data
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      ara_op_o     <= acc_op_i;
      ara_vd_o     <= acc_vd_i;
      ara_vs1_o    <= acc_vs1_i;
      ara_vs2_o    <= acc_vs2_i;
      ara_scalar_o <= acc_scalar_i;
      ara_addr_o   <= acc_addr_i;
      // Loads and stores go to the VLSU
      ara_target_o <= (acc_op_i == VLE || acc_op_i == VSE) ? PeVlsu : PeLanes;
    end
    // Only the scalar move returns data
    if (ara_done_i) begin
      acc_resp_result_o <= (ara_op_o == VMVXS) ? ara_result_i : '0;
    end
  end

endmodule : ara_dispatcher

/* vlsu.sv */
//////////////////////////////
// Vector load/store unit
// Walks one vector element per cycle over the word memory port
//////////////////////////////

`timescale 1ns/1ps

module vlsu (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // Sequencer
  input  logic                          vlsu_req_i,
  input  ara_pkg::op_e                  op_i,
  input  ara_pkg::vreg_t                vd_i,
  input  ara_pkg::vreg_t                vs2_i,
  input  ara_pkg::mem_addr_t            addr_i,
  output logic                          vlsu_done_o,
  // Memory port
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output ara_pkg::mem_addr_t            mem_addr_o,
  output ara_pkg::elem_t                mem_wdata_o,
  input  ara_pkg::elem_t                mem_rdata_i,
  // Lane load writes
  output logic [ara_pkg::NrLanes-1:0]   ldu_we_o,
  output ara_pkg::vreg_t                ldu_vreg_o,
  output ara_pkg::lane_idx_t            ldu_idx_o,
  output ara_pkg::elem_t                ldu_wdata_o,
  // Lane store reads
  output ara_pkg::vreg_t                stu_vreg_o,
  output ara_pkg::lane_idx_t            stu_idx_o,
  input  ara_pkg::elem_t                stu_rdata_i [ara_pkg::NrLanes]
);

  import ara_pkg::*;

  logic      active_q;
  elem_cnt_t cnt_q;
  logic      is_load;
  logic      last_elem;
  lane_sel_t st_lane;
  // Load data returns one cycle after the read
  logic      ld_pend_q;
  elem_cnt_t ld_cnt_q;
  logic      ld_last;

  assign is_load   = (op_i == VLE);
  assign last_elem = (cnt_q == elem_cnt_t'(VLenElems - 1));
  assign ld_last   = (ld_cnt_q == elem_cnt_t'(VLenElems - 1));
  assign st_lane   = cnt_q[LaneSelWidth-1:0];

  //////////////////////////////
  // Memory requests
  //////////////////////////////

  assign mem_req_o   = active_q;
  assign mem_we_o    = active_q && !is_load;
  assign mem_addr_o  = addr_i + mem_addr_t'(cnt_q);
  assign mem_wdata_o = stu_rdata_i[st_lane];

  // Element i sits in lane i mod NrLanes at index i div NrLanes
  assign stu_vreg_o = vs2_i;
  assign stu_idx_o  = cnt_q[ElemCntWidth-1:LaneSelWidth];

  //////////////////////////////
  // Load writeback
  //////////////////////////////

  assign ldu_vreg_o  = vd_i;
  assign ldu_idx_o   = ld_cnt_q[ElemCntWidth-1:LaneSelWidth];
  assign ldu_wdata_o = mem_rdata_i;

  always_comb begin
    ldu_we_o = '0;
    if (ld_pend_q) begin
      ldu_we_o[ld_cnt_q[LaneSelWidth-1:0]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q    <= 1'b0;
      cnt_q       <= '0;
      ld_pend_q   <= 1'b0;
      vlsu_done_o <= 1'b0;
    end else begin
      ld_pend_q   <= active_q && is_load;
      // Stores end on the last write, loads on the last writeback
      vlsu_done_o <= (active_q && !is_load && last_elem) || (ld_pend_q && ld_last);
      if (vlsu_req_i) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (active_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (last_elem) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    ld_cnt_q <= cnt_q;
  end

endmodule : vlsu

/* lane.sv */
//////////////////////////////
// Vector lane
// Holds this lane's slice of the register file and runs the
// elementwise integer ops, one element per cycle
//////////////////////////////

`timescale 1ns/1ps

module lane (
  input  logic               clk_i,
  input  logic               reset_i,
  // Sequencer
  input  logic               lane_req_i,
  input  ara_pkg::op_e       op_i,
  input  ara_pkg::vreg_t     vd_i,
  input  ara_pkg::vreg_t     vs1_i,
  input  ara_pkg::vreg_t     vs2_i,
  input  ara_pkg::elem_t     scalar_i,
  output logic               lane_done_o,
  // Load unit write port
  input  logic               ldu_we_i,
  input  ara_pkg::vreg_t     ldu_vreg_i,
  input  ara_pkg::lane_idx_t ldu_idx_i,
  input  ara_pkg::elem_t     ldu_wdata_i,
  // Store unit read port
  input  ara_pkg::vreg_t     stu_vreg_i,
  input  ara_pkg::lane_idx_t stu_idx_i,
  output ara_pkg::elem_t     stu_rdata_o,
  // Element 0 of vs2, used by the scalar move
  output ara_pkg::elem_t     elem0_o
);

  import ara_pkg::*;

  // Register file slice
  elem_t     vrf_q [NrVRegs][ElemsPerLane];

  logic      busy_q;
  lane_idx_t idx_q;
  logic      last_idx;
  elem_t     op_a;
  elem_t     op_b;
  elem_t     result;

  //////////////////////////////
  // ALU
  //////////////////////////////

  // a is vs2, b is vs1
  function automatic elem_t alu(op_e op, elem_t a, elem_t b, elem_t s);
    case (op)
      VADD:    return a + b;
      VSUB:    return a - b;
      VAND:    return a & b;
      VOR:     return a | b;
      VXOR:    return a ^ b;
      VADDX:   return a + s;
      default: return a;
    endcase
  endfunction

  assign op_a     = vrf_q[vs2_i][idx_q];
  assign op_b     = vrf_q[vs1_i][idx_q];
  assign result   = alu(op_i, op_a, op_b, scalar_i);
  assign last_idx = (idx_q == lane_idx_t'(ElemsPerLane - 1));

  //////////////////////////////
  // Element sequencing
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q      <= 1'b0;
      idx_q       <= '0;
      lane_done_o <= 1'b0;
    end else begin
      lane_done_o <= busy_q && last_idx;
      if (lane_req_i) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end else if (busy_q) begin
        idx_q <= idx_q + 1'b1;
        if (last_idx) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////
  // Register file ports
  //////////////////////////////

  // ALU and load never run together, the sequencer issues one op at a time
  always_ff @(posedge clk_i) begin
    if (busy_q && op_i != VMVXS) begin
      vrf_q[vd_i][idx_q] <= result;
    end else if (ldu_we_i) begin
      vrf_q[ldu_vreg_i][ldu_idx_i] <= ldu_wdata_i;
    end
  end

  assign stu_rdata_o = vrf_q[stu_vreg_i][stu_idx_i];
  assign elem0_o     = vrf_q[vs2_i][0];

endmodule : lane

/* ara_pkg.sv */
//////////////////////////////
// Vector coprocessor package
// Lane geometry, element and address types, opcode and unit encodings
//////////////////////////////

package ara_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned NrLanes      = 2;
  localparam int unsigned ElemsPerLane = 4;
  // One full register, vl is fixed
  localparam int unsigned VLenElems    = NrLanes * ElemsPerLane;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned AddrWidth    = 16;

  // Element counter over a whole vector, low bits select the lane
  localparam int unsigned ElemCntWidth = $clog2(VLenElems);
  localparam int unsigned LaneSelWidth = $clog2(NrLanes);

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [ElemWidth-1:0]             elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]       vreg_t;
  typedef logic [$clog2(ElemsPerLane)-1:0]  lane_idx_t;
  typedef logic [AddrWidth-1:0]             mem_addr_t;
  typedef logic [ElemCntWidth-1:0]          elem_cnt_t;
  typedef logic [LaneSelWidth-1:0]          lane_sel_t;

  // Vector opcodes
  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VADDX,
    VMVXS,
    VLE,
    VSE
  } op_e;

  // Processing element that runs an instruction
  typedef enum logic {
    PeLanes,
    PeVlsu
  } pe_e;

  // Sequencer FSM
  typedef enum logic [1:0] {
    Idle,
    Issue,
    Wait,
    Done
  } seq_state_e;

endpackage : ara_pkg
